//--- line_mirror.f
+incdir+.
wr_req_pkg.sv
line_buf_pkg.sv
line_fill_ctrl.sv
line_store.sv
line_drain.sv
line_mirror_top.sv
tb_line_mirror.sv

//--- tb_line_mirror.sv
// Self-checking testbench for the write-path line mirror
// LFSR driven producer and consumer, checked against a queue model of the mirror rule
`timescale 1ns/1ps
`include "line_mirror_macros.svh"

module tb_line_mirror;

   logic                 Clk_400;
   logic                 rst;
   wr_req_pkg::wr_word_t in_word;
   logic                 in_en;
   logic                 full;
   logic                 almost_full;
   wr_req_pkg::wr_word_t out_word;
   logic                 out_valid;
   logic                 out_ready;

   // Model state
   wr_req_pkg::wr_word_t acc_q[$];
   wr_req_pkg::wr_word_t exp_q[$];
   wr_req_pkg::wr_word_t exp_w;
   int                   tx_cnt = 0;
   int                   rx_cnt = 0;
   logic [15:0]          lfsr_state = 16'd64648;

   line_mirror_top dut_i (
      .Clk_400     (Clk_400),
      .rst         (rst),
      .in_word     (in_word),
      .in_en       (in_en),
      .full        (full),
      .almost_full (almost_full),
      .out_word    (out_word),
      .out_valid   (out_valid),
      .out_ready   (out_ready)
   );

   // 10 ns clock
   always #5 Clk_400 = ~Clk_400;

   // ----------------------------------------
   // Random source
   // ----------------------------------------
   // 16-bit Galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      lfsr_step = (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
   endfunction

   // One LFSR step per bit taken for up to 32 bits
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r[i] = lfsr_state[0];
         lfsr_state = lfsr_step(lfsr_state);
      end
      rand_bits = r;
   endfunction

   // Fresh random word built payload lanes first and header fields last
   function automatic wr_req_pkg::wr_word_t make_word();
      wr_req_pkg::wr_word_t w;
      logic [31:0]          t;
      for (int l = 0; l < `LM_DATA_W / 32; l++) begin
         w.data[l*32 +: 32] = rand_bits(32);
      end
      t = rand_bits(`LM_ADDR_W);
      w.hdr.addr = t[`LM_ADDR_W-1:0];
      t = rand_bits(`LM_TID_W);
      w.hdr.tid = t[`LM_TID_W-1:0];
      t = rand_bits(1);
      w.hdr.fence = t[0];
      t = rand_bits(`LM_LEN_W);
      w.hdr.len = t[`LM_LEN_W-1:0];
      t = rand_bits(1);
      w.hdr.sop = t[0];
      make_word = w;
   endfunction

   // ----------------------------------------
   // Reference model
   // ----------------------------------------
   // Pixel byte order per 32-bit lane
   // out byte 3 from byte 1, out byte 1 from byte 3, bytes 2 and 0 in place
   function automatic wr_req_pkg::cache_line_t swizzle_ref(input wr_req_pkg::cache_line_t d);
      wr_req_pkg::cache_line_t r;
      int                      src;
      for (int l = 0; l < `LM_DATA_W / 32; l++) begin
         for (int b = 0; b < 4; b++) begin
            src = (b == 3) ? 1 : ((b == 1) ? 3 : b);
            r[l*32 + b*8 +: 8] = d[l*32 + src*8 +: 8];
         end
      end
      swizzle_ref = r;
   endfunction

   // A full group of 60 becomes 60 expected outputs
   // with header k in order and the payload from word 59-k
   task automatic build_bank();
      wr_req_pkg::wr_word_t e;
      for (int k = 0; k < `LM_LINE_WORDS; k++) begin
         e.hdr  = acc_q[k].hdr;
         e.data = swizzle_ref(acc_q[`LM_LINE_WORDS-1-k].data);
         exp_q.push_back(e);
      end
      acc_q.delete();
   endtask

   // ----------------------------------------
   // Failure and compare
   // ----------------------------------------
   task automatic fail_now(input string msg);
      $display("Error at time %0t: %s", $time, msg);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_hdr(input wr_req_pkg::wr_hdr_t got, input wr_req_pkg::wr_hdr_t exp,
                            input string what);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s header got %h expected %h", $time, what, got, exp);
         fail_now("output header differs from model");
      end
   endtask

   task automatic check_line(input wr_req_pkg::cache_line_t got,
                             input wr_req_pkg::cache_line_t exp, input string what);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s payload got %h expected %h", $time, what, got, exp);
         fail_now("output payload differs from model");
      end
   endtask

   // ----------------------------------------
   // Monitor
   // ----------------------------------------
   // Sampled mid-cycle where values hold through the next rising edge
   always @(negedge Clk_400) begin
      if (!rst) begin
         if (full === 1'b1 && almost_full !== 1'b1) begin
            fail_now("full is high while almost_full is low");
         end
         // Word taken at the coming edge
         if (in_en && !full) begin
            acc_q.push_back(in_word);
            tx_cnt++;
            if (acc_q.size() == `LM_LINE_WORDS) begin
               build_bank();
            end
         end
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               fail_now("output transfer while the model holds no complete bank");
            end
            exp_w = exp_q.pop_front();
            check_hdr(out_word.hdr, exp_w.hdr, $sformatf("word %0d", rx_cnt));
            check_line(out_word.data, exp_w.data, $sformatf("word %0d", rx_cnt));
            rx_cnt++;
         end
      end
   end

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial begin
      int   cycles;
      bit   done;
      int   tx_target;
      int   rx_target;
      logic [31:0] t;
      Clk_400   = 1'b0;
      rst       = 1'b1;
      in_en     = 1'b0;
      in_word   = '0;
      out_ready = 1'b0;

      // Reset for 4 cycles
      repeat (4) @(posedge Clk_400);
      rst <= 1'b0;
      @(negedge Clk_400);
      if (full !== 1'b0 || almost_full !== 1'b0 || out_valid !== 1'b0) begin
         fail_now("full, almost_full or out_valid not low after reset");
      end

      // Consumer stalled until both banks fill
      @(posedge Clk_400);
      in_en   <= 1'b1;
      in_word <= make_word();
      cycles = 0;
      done   = 1'b0;
      while (!done && cycles < 400) begin
         @(negedge Clk_400);
         if (full === 1'b1) begin
            done = 1'b1;
         end else begin
            @(posedge Clk_400);
            in_word <= make_word();
            cycles++;
         end
      end
      if (!done) begin
         fail_now("timeout waiting for full with the consumer stalled");
      end
      @(posedge Clk_400);
      if (tx_cnt != `LM_STORE_WORDS) begin
         fail_now($sformatf("full rose after %0d accepted words, not 120", tx_cnt));
      end

      // Keep pushing while full and expect nothing to enter
      repeat (20) begin
         @(posedge Clk_400);
         in_word <= make_word();
      end
      @(negedge Clk_400);
      if (tx_cnt != `LM_STORE_WORDS || full !== 1'b1 || out_valid !== 1'b1) begin
         fail_now("store did not hold full and valid while the consumer was stalled");
      end

      // Release and drain both banks
      @(posedge Clk_400);
      in_en     <= 1'b0;
      out_ready <= 1'b1;
      rx_target = `LM_STORE_WORDS;
      cycles = 0;
      while (rx_cnt < rx_target && cycles < 500) begin
         @(posedge Clk_400);
         cycles++;
      end
      if (rx_cnt < rx_target) begin
         fail_now("timeout draining the two stalled banks");
      end

      // 600 more words end to end under random traffic
      tx_target = tx_cnt + 600;
      rx_target = rx_cnt + 600;
      cycles = 0;
      while (rx_cnt < rx_target && cycles < 20000) begin
         @(posedge Clk_400);
         in_word <= make_word();
         // Producer busy three cycles in four
         t = rand_bits(2);
         in_en <= (tx_cnt < tx_target) && (t[1:0] != 2'b00);
         t = rand_bits(1);
         out_ready <= t[0];
         cycles++;
      end
      if (rx_cnt < rx_target) begin
         fail_now("timeout under random producer and consumer traffic");
      end
      @(posedge Clk_400);
      in_en     <= 1'b0;
      out_ready <= 1'b0;
      repeat (2) @(posedge Clk_400);

      if (tx_cnt == rx_cnt && acc_q.size() == 0 && exp_q.size() == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         $display("Error: %0d words accepted but %0d delivered", tx_cnt, rx_cnt);
         $display("TEST FAIL");
         $fatal(1, "words left over in the model");
      end
   end

endmodule

//--- line_mirror_top.sv
// Top of the write-path line mirror
// Producer words in, mirrored and swizzled words out, the three blocks wired together
`timescale 1ns/1ps

module line_mirror_top (
   input  logic                 Clk_400,
   input  logic                 rst,
   // Producer side
   input  wr_req_pkg::wr_word_t in_word,
   input  logic                 in_en,
   output logic                 full,
   output logic                 almost_full,
   // Consumer side
   output wr_req_pkg::wr_word_t out_word,
   output logic                 out_valid,
   input  logic                 out_ready
);

   // Store write port
   logic                    wr_en;
   line_buf_pkg::word_idx_t wr_idx;
   wr_req_pkg::wr_word_t    wr_word;
   // Store read port
   line_buf_pkg::word_idx_t rd_idx;
   wr_req_pkg::wr_word_t    rd_word;
   // Bank hand-off between fill and drain
   logic                    banks_ready;
   logic                    bank_drained;

   // ----------------------------------------
   // Fill side
   // ----------------------------------------
   line_fill_ctrl fill_i (
      .Clk_400      (Clk_400),
      .rst          (rst),
      .in_word      (in_word),
      .in_en        (in_en),
      .bank_drained (bank_drained),
      .wr_en        (wr_en),
      .wr_idx       (wr_idx),
      .wr_word      (wr_word),
      .banks_ready  (banks_ready),
      .full         (full),
      .almost_full  (almost_full)
   );

   // Word memory
   line_store store_i (
      .Clk_400 (Clk_400),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .wr_word (wr_word),
      .rd_idx  (rd_idx),
      .rd_word (rd_word)
   );

   // ----------------------------------------
   // Drain side
   // ----------------------------------------
   line_drain drain_i (
      .Clk_400      (Clk_400),
      .rst          (rst),
      .banks_ready  (banks_ready),
      .rd_word      (rd_word),
      .out_ready    (out_ready),
      .rd_idx       (rd_idx),
      .out_word     (out_word),
      .out_valid    (out_valid),
      .bank_drained (bank_drained)
   );

endmodule

//--- line_drain.sv
// Output side of the line mirror
// Walks each bank from the top down, swizzles payload bytes and reports bank completion
`timescale 1ns/1ps
`include "line_mirror_macros.svh"

module line_drain (
   input  logic                    Clk_400,
   input  logic                    rst,
   input  logic                    banks_ready,
   input  wr_req_pkg::wr_word_t    rd_word,
   input  logic                    out_ready,
   output line_buf_pkg::word_idx_t rd_idx,
   output wr_req_pkg::wr_word_t    out_word,
   output logic                    out_valid,
   output logic                    bank_drained
);

   localparam line_buf_pkg::word_idx_t bank0_last  = `LM_LINE_WORDS - 1;
   localparam line_buf_pkg::word_idx_t bank1_first = `LM_LINE_WORDS;
   localparam line_buf_pkg::word_idx_t store_last  = `LM_STORE_WORDS - 1;
   localparam int                      lanes       = `LM_DATA_W / `LM_LANE_W;

   line_buf_pkg::word_idx_t ridx_q;
   logic                    xfer;

   // Byte order of one packed pixel lane
   // Bytes 3 and 1 trade places, 2 and 0 stay
   function automatic logic [`LM_LANE_W-1:0] swizzle_lane(
      input logic [`LM_LANE_W-1:0] lane
   );
      swizzle_lane = {lane[15:8], lane[23:16], lane[31:24], lane[7:0]};
   endfunction

   // ----------------------------------------
   // Handshake
   // ----------------------------------------
   // Valid as long as any complete bank waits
   assign out_valid = banks_ready;
   assign xfer      = out_valid & out_ready;

   // Bottom of either bank is its last word out
   assign bank_drained = xfer & ((ridx_q == '0) || (ridx_q == bank1_first));

   // ----------------------------------------
   // Read walk
   // ----------------------------------------
   // 59 down to 0, then 119 down to 60, then 59 again
   // Stepping below 60 lands on 59 without a special case
   always_ff @(posedge Clk_400) begin
      if (rst) begin
         ridx_q <= bank0_last;
      end else if (xfer) begin
         ridx_q <= (ridx_q == '0) ? store_last : ridx_q - 1'b1;
      end
   end

   assign rd_idx = ridx_q;

   // ----------------------------------------
   // Output word
   // ----------------------------------------
   // Header passes as read, payload gets the lane swizzle
   always_comb begin
      out_word.hdr = rd_word.hdr;
      for (int l = 0; l < lanes; l++) begin
         out_word.data[l*`LM_LANE_W +: `LM_LANE_W] =
            swizzle_lane(rd_word.data[l*`LM_LANE_W +: `LM_LANE_W]);
      end
   end

   // ----------------------------------------
   // Checks
   // ----------------------------------------
   // A bank starts out at its top word
   // so the walk stays in step with the fill side
   a_walk_aligned: assert property (@(posedge Clk_400) disable iff (rst)
      $rose(out_valid) |-> ((rd_idx == bank0_last) || (rd_idx == store_last)));

   // Stalled output holds, so the fill side never touches the bank in flight
   a_stall_holds: assert property (@(posedge Clk_400) disable iff (rst)
      (out_valid && !out_ready) |=> $stable(out_word));

endmodule

//--- line_store.sv
// Two-bank word memory of the line mirror
// One write port, one read port returning the mirrored header with the direct payload
`timescale 1ns/1ps
`include "line_mirror_macros.svh"

module line_store (
   input  logic                    Clk_400,
   input  logic                    wr_en,
   input  line_buf_pkg::word_idx_t wr_idx,
   input  wr_req_pkg::wr_word_t    wr_word,
   input  line_buf_pkg::word_idx_t rd_idx,
   output wr_req_pkg::wr_word_t    rd_word
);

   localparam line_buf_pkg::word_idx_t bank1_base = `LM_LINE_WORDS;
   localparam line_buf_pkg::word_idx_t last_pos   = `LM_LINE_WORDS - 1;

   // Both banks back to back
   wr_req_pkg::wr_word_t    mem [0:`LM_STORE_WORDS-1];
   line_buf_pkg::word_idx_t bank_base;
   line_buf_pkg::word_idx_t mirror_idx;

   // Write port
   always_ff @(posedge Clk_400) begin
      if (wr_en) begin
         mem[wr_idx] <= wr_word;
      end
   end

   // ----------------------------------------
   // Mirrored read
   // ----------------------------------------
   // Start of the bank that rd_idx points into
   assign bank_base  = (rd_idx >= bank1_base) ? bank1_base : '0;
   // Same bank, position 59 minus the read position
   assign mirror_idx = bank_base + (last_pos - (rd_idx - bank_base));

   // Drain walks down, so headers come out in arrival order
   // while payloads come out reversed
   always_comb begin
      rd_word.hdr  = mem[mirror_idx].hdr;
      rd_word.data = mem[rd_idx].data;
   end

endmodule

//--- line_fill_ctrl.sv
// Input side of the line mirror
// Accepts words, tracks the write index and bank occupancy, raises full and almost-full
`timescale 1ns/1ps
`include "line_mirror_macros.svh"

module line_fill_ctrl (
   input  logic                    Clk_400,
   input  logic                    rst,
   input  wr_req_pkg::wr_word_t    in_word,
   input  logic                    in_en,
   input  logic                    bank_drained,
   output logic                    wr_en,
   output line_buf_pkg::word_idx_t wr_idx,
   output wr_req_pkg::wr_word_t    wr_word,
   output logic                    banks_ready,
   output logic                    full,
   output logic                    almost_full
);

   localparam line_buf_pkg::word_idx_t bank1_base  = `LM_LINE_WORDS;
   localparam line_buf_pkg::word_idx_t last_pos    = `LM_LINE_WORDS - 1;
   localparam line_buf_pkg::word_idx_t store_last  = `LM_STORE_WORDS - 1;
   localparam line_buf_pkg::word_idx_t almfull_pos = `LM_ALMFULL_IDX;
   localparam line_buf_pkg::bank_cnt_t cnt_full    = `LM_NUM_BANKS;
   localparam line_buf_pkg::bank_cnt_t cnt_one     = `LM_NUM_BANKS - 1;

   line_buf_pkg::word_idx_t widx_q;
   line_buf_pkg::word_idx_t widx_nxt;
   line_buf_pkg::word_idx_t bank_pos;
   line_buf_pkg::bank_cnt_t occ_q;
   logic                    accept;
   logic                    last_word;
   logic                    last_q;
   logic                    alm_set;
   logic                    alm_q;

   // ----------------------------------------
   // Accept and write
   // ----------------------------------------
   assign accept  = in_en & ~full;
   // Every accepted word lands in the store the same cycle
   assign wr_en   = accept;
   assign wr_idx  = widx_q;
   assign wr_word = in_word;

   // Position of the write index inside its bank
   assign bank_pos  = (widx_q >= bank1_base) ? widx_q - bank1_base : widx_q;
   assign last_word = (bank_pos == last_pos);
   // Wrap from the top of bank 1 back to bank 0
   assign widx_nxt  = (widx_q == store_last) ? '0 : widx_q + 1'b1;

   always_ff @(posedge Clk_400) begin
      if (rst) begin
         widx_q <= '0;
      end else if (accept) begin
         widx_q <= widx_nxt;
      end
   end

   // Bank completion seen one cycle late
   always_ff @(posedge Clk_400) begin
      if (rst) begin
         last_q <= 1'b0;
      end else begin
         last_q <= last_word & accept;
      end
   end

   // ----------------------------------------
   // Bank occupancy
   // ----------------------------------------
   // Completion and drain in the same cycle cancel out
   always_ff @(posedge Clk_400) begin
      if (rst) begin
         occ_q <= '0;
      end else if (last_q && !bank_drained) begin
         occ_q <= occ_q + 1'b1;
      end else if (!last_q && bank_drained) begin
         occ_q <= occ_q - 1'b1;
      end
   end

   assign banks_ready = (occ_q != '0);
   // Also full while the second completion is still in flight
   // so nothing lands on the undrained bank
   assign full = (occ_q == cnt_full) | (last_q & (occ_q == cnt_one));

   // Warn when the bank being filled nears its end and the other one is still waiting
   assign alm_set = accept & (bank_pos == almfull_pos) & (occ_q == cnt_one);

   // Sticky until a bank leaves
   always_ff @(posedge Clk_400) begin
      if (rst) begin
         alm_q <= 1'b0;
      end else if (bank_drained) begin
         alm_q <= 1'b0;
      end else if (alm_set) begin
         alm_q <= 1'b1;
      end
   end

   assign almost_full = alm_q;

   // ----------------------------------------
   // Checks
   // ----------------------------------------
   // Full only lets go after the drain side hands back a bank
   a_full_holds: assert property (@(posedge Clk_400) disable iff (rst)
      (full && !bank_drained) |=> !wr_en);

   // Never more complete banks than the store holds
   a_occ_max: assert property (@(posedge Clk_400) disable iff (rst)
      occ_q <= cnt_full);

endmodule

//--- line_buf_pkg.sv
// Types of the two-bank buffer control
// Store index and the count of complete banks
`include "line_mirror_macros.svh"

package line_buf_pkg;

   // Index into the whole store, both banks back to back
   // Bank 0 holds 0 to 59, bank 1 holds 60 to 119
   typedef logic [`LM_IDX_W-1:0] word_idx_t;

   // Complete banks waiting to drain, 0 up to the bank count
   typedef logic [$clog2(`LM_NUM_BANKS+1)-1:0] bank_cnt_t;

endpackage

//--- wr_req_pkg.sv
// Types of a write request word as it travels through the line mirror
// Header fields first, then the header and the full stored word
`include "line_mirror_macros.svh"

package wr_req_pkg;

   // ----------------------------------------
   // Header field vectors
   // ----------------------------------------
   typedef logic [`LM_ADDR_W-1:0] line_addr_t;
   typedef logic [`LM_TID_W-1:0]  req_tid_t;
   // Number of lines in a multi-line request
   typedef logic [`LM_LEN_W-1:0]  req_len_t;
   typedef logic [`LM_DATA_W-1:0] cache_line_t;

   // Header of one write, 40 bits
   // Field order follows the requestor's packing
   typedef struct packed {
      line_addr_t addr;
      req_tid_t   tid;
      // Write fence
      logic       fence;
      req_len_t   len;
      // First line of a packet
      logic       sop;
   } wr_hdr_t;

   // Stored word, header on top of the payload
   typedef struct packed {
      wr_hdr_t     hdr;
      cache_line_t data;
   } wr_word_t;

endpackage

//--- line_mirror_macros.svh
// Shared constants for the write-path line mirror
// Included by both packages and by every RTL module that needs a size
`ifndef LINE_MIRROR_MACROS_SVH
`define LINE_MIRROR_MACROS_SVH

// ----------------------------------------
// Store geometry
// ----------------------------------------
// Words per bank, fixed by the mirror rule
`define LM_LINE_WORDS   60
// Two banks, one filling while the other drains
`define LM_NUM_BANKS    2
`define LM_STORE_WORDS  120
// Index width covering the whole store
`define LM_IDX_W        7

// ----------------------------------------
// Word layout
// ----------------------------------------
// Cache-line payload
`define LM_DATA_W       512
// Swizzle works on 32-bit pixel lanes
`define LM_LANE_W       32
`define LM_ADDR_W       20
`define LM_TID_W        16
// Multi-line length code
`define LM_LEN_W        2

// Bank position that raises the early warning
`define LM_ALMFULL_IDX  55

`endif
